// ==== video_cfg.svh ====
// fixed 640x480 timing, fetch window and register map of the text video generator, include where needed
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// horizontal timing in pixels with blanking left of the visible area
`define VID_H_VISIBLE       640
`define VID_H_FRONT         16
`define VID_H_SYNC          96
`define VID_H_BACK          48

// vertical timing in lines with blanking below the visible area
`define VID_V_VISIBLE       480
`define VID_V_FRONT         10
`define VID_V_SYNC          2
`define VID_V_BACK          33

`define VID_H_SYNC_POL      1'b0            // active low hsync
`define VID_V_SYNC_POL      1'b0            // active low vsync

`define VID_FETCH_LEAD      9               // window opens this far ahead of the visible area
`define VID_FETCH_TAIL      4               // window closes this far ahead of line end

// register numbers seen on the write port
`define VID_REG_DISPSTART   3'd0            // vram word address of the first tile
`define VID_REG_TILEWIDTH   3'd1            // vram words per text row
`define VID_REG_FONTCTRL    3'd3            // bank in 15:13 and cell height minus 1 in 3:0

// reset values
`define VID_TEXT_START      16'h0000        // text starts at vram 0
`define VID_TILES_WIDE      80              // 640 / 8 tiles
`define VID_FONT_HEIGHT     4'd15           // 8x16 cells

`define VID_FEATURES        16'h8001        // constant feature word on readback 2

`endif

// ==== video_pkg.sv ====
// shared widths, scan state enum and the structs passed between the video blocks, import where used
package video_pkg;

    typedef logic [10:0] scan_cnt_t;        // horizontal or vertical position
    typedef logic [15:0] vram_addr_t;       // vram word address
    typedef logic [15:0] vram_word_t;       // char in low byte and colour in high byte
    typedef logic [11:0] font_addr_t;       // font ram word address
    typedef logic [15:0] font_word_t;       // two glyph rows with the even row on top
    typedef logic [3:0]  pal_index_t;       // palette index of one pixel
    typedef logic [2:0]  reg_num_t;         // config register number
    typedef logic [15:0] reg_word_t;        // config register data

    // phases in scan order so a phase end steps to the next code
    typedef enum logic [1:0] {
        PRE_SYNC  = 2'b00,                  // front porch
        SYNC      = 2'b01,
        POST_SYNC = 2'b10,                  // back porch
        VISIBLE   = 2'b11
    } sync_state_e;

    // text layout written by the host
    typedef struct packed {
        vram_addr_t text_start;             // first tile word of a frame
        vram_addr_t line_width;             // words per text row
        logic [3:0] font_height;            // rows per cell minus 1
        logic [2:0] font_bank;              // font ram bank
    } text_cfg_t;

    // scan position as seen by the fetch and register blocks
    typedef struct packed {
        sync_state_e h_state;
        sync_state_e v_state;
        scan_cnt_t   v_count;               // current line
        logic        fetch;                 // memory fetch window
        logic        line_end;              // last pixel of a line
        logic        frame_end;             // last pixel of a frame
    } scan_state_t;

endpackage

// ==== video_sync.sv ====
// free running 640x480 scan generator giving sync, raw display enable and the shared scan state
`timescale 1ns/1ps
`include "video_cfg.svh"

module video_sync
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    output scan_state_t scan_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        de_o
);

    localparam int H_OFFSCREEN = `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK;  // 160 blank pixels
    localparam int H_TOTAL     = H_OFFSCREEN + `VID_H_VISIBLE;              // 800 clocks
    localparam int V_TOTAL     = `VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK;
    localparam int FETCH_OPEN  = H_OFFSCREEN - `VID_FETCH_LEAD;             // first h_count in window
    localparam int FETCH_CLOSE = H_TOTAL - `VID_FETCH_TAIL;                 // first h_count past it

    sync_state_e h_state;
    sync_state_e h_state_next;
    sync_state_e v_state;
    sync_state_e v_state_next;
    scan_cnt_t   h_count;
    scan_cnt_t   h_count_next;
    scan_cnt_t   h_end;                     // last count of the current h phase
    scan_cnt_t   v_count;
    scan_cnt_t   v_count_next;
    scan_cnt_t   v_end;                     // last line of the current v phase
    logic        fetch;
    logic        fetch_next;
    logic        line_end;
    logic        frame_end;

    always_comb begin
        case (h_state)
            PRE_SYNC:  h_end = scan_cnt_t'(`VID_H_FRONT - 1);
            SYNC:      h_end = scan_cnt_t'(`VID_H_FRONT + `VID_H_SYNC - 1);
            POST_SYNC: h_end = scan_cnt_t'(H_OFFSCREEN - 1);
            default:   h_end = scan_cnt_t'(H_TOTAL - 1);         // visible runs to line end
        endcase
    end

    always_comb begin
        case (v_state)
            VISIBLE:   v_end = scan_cnt_t'(`VID_V_VISIBLE - 1);  // visible lines come first
            PRE_SYNC:  v_end = scan_cnt_t'(`VID_V_VISIBLE + `VID_V_FRONT - 1);
            SYNC:      v_end = scan_cnt_t'(`VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC - 1);
            default:   v_end = scan_cnt_t'(V_TOTAL - 1);
        endcase
    end

    assign line_end     = (h_state == VISIBLE) && (h_count == h_end);
    assign frame_end    = line_end && (v_state == POST_SYNC) && (v_count == v_end);
    assign h_state_next = (h_count == h_end) ? sync_state_e'(h_state + 2'd1) : h_state;
    assign v_state_next = (line_end && v_count == v_end) ? sync_state_e'(v_state + 2'd1)
                                                          : v_state;
    assign h_count_next = line_end ? '0 : h_count + 1'b1;
    assign v_count_next = frame_end ? '0 : (line_end ? v_count + 1'b1 : v_count);

    // window is registered so it is high for h_count in [open, close) of visible lines
    assign fetch_next = (v_state == VISIBLE) &&
                        (h_count >= scan_cnt_t'(FETCH_OPEN - 1)) &&
                        (h_count <  scan_cnt_t'(FETCH_CLOSE - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= PRE_SYNC;
            v_state <= VISIBLE;
            h_count <= '0;
            v_count <= '0;
            fetch   <= 1'b0;
            hsync_o <= ~`VID_H_SYNC_POL;    // idle level
            vsync_o <= ~`VID_V_SYNC_POL;
            de_o    <= 1'b0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            h_count <= h_count_next;
            v_count <= v_count_next;
            fetch   <= fetch_next;
            hsync_o <= (h_state == SYNC) ? `VID_H_SYNC_POL : ~`VID_H_SYNC_POL;
            vsync_o <= (v_state == SYNC) ? `VID_V_SYNC_POL : ~`VID_V_SYNC_POL;
            de_o    <= (h_state == VISIBLE) && (v_state == VISIBLE);  // one clock behind scan
        end
    end

    always_comb begin
        scan_o.h_state   = h_state;
        scan_o.v_state   = v_state;
        scan_o.v_count   = v_count;
        scan_o.fetch     = fetch;
        scan_o.line_end  = line_end;
        scan_o.frame_end = frame_end;
    end

    // blank pixels sit at the start of every line
    a_line_wrap: assert property (@(posedge clk) disable iff (reset_i)
        line_end |=> (h_state == PRE_SYNC));

endmodule

// ==== video_regs.sv ====
// host config registers for the text layout plus the registered geometry, feature and status readback
`timescale 1ns/1ps
`include "video_cfg.svh"

module video_regs
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  scan_state_t scan_i,
    input  logic        reg_wr_i,
    input  reg_num_t    reg_num_i,
    input  reg_word_t   reg_data_i,
    output text_cfg_t   cfg_o,
    output reg_word_t   reg_data_o
);

    text_cfg_t cfg_q;
    reg_word_t status;                      // blanking flags and current line

    assign status = {scan_i.v_state != VISIBLE, scan_i.h_state != VISIBLE, 3'b000,
                     scan_i.v_count};
    assign cfg_o  = cfg_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_q.text_start  <= `VID_TEXT_START;
            cfg_q.line_width  <= vram_addr_t'(`VID_TILES_WIDE);
            cfg_q.font_height <= `VID_FONT_HEIGHT;
            cfg_q.font_bank   <= 3'b000;
        end else if (reg_wr_i) begin
            case (reg_num_i)
                `VID_REG_DISPSTART: begin
                    cfg_q.text_start <= reg_data_i;
                end
                `VID_REG_TILEWIDTH: begin
                    cfg_q.line_width <= reg_data_i;
                end
                `VID_REG_FONTCTRL: begin
                    cfg_q.font_height <= reg_data_i[3:0];    // rows minus 1
                    cfg_q.font_bank   <= reg_data_i[15:13];
                end
                default: begin
                end                                          // unmapped numbers ignored
            endcase
        end
    end

    // readback follows the low two bits of the number one clock later
    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_data_o <= '0;
        end else begin
            case (reg_num_i[1:0])
                2'd0:    reg_data_o <= reg_word_t'(`VID_H_VISIBLE);
                2'd1:    reg_data_o <= reg_word_t'(`VID_V_VISIBLE);
                2'd2:    reg_data_o <= `VID_FEATURES;
                default: reg_data_o <= status;
            endcase
        end
    end

    // a one row cell would leave no second glyph row in the font word
    a_font_height: assert property (@(posedge clk) disable iff (reset_i)
        (reg_wr_i && reg_num_i == `VID_REG_FONTCTRL) |=> (cfg_o.font_height != 4'd0));

endmodule

// ==== text_fetch.sv ====
// per tile vram and font ram fetch sequencer that shifts glyph rows out as palette indices
`timescale 1ns/1ps
`include "video_cfg.svh"

module text_fetch
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  scan_state_t scan_i,
    input  text_cfg_t   cfg_i,
    input  logic        enable_i,
    input  vram_word_t  vram_data_i,
    input  font_word_t  font_data_i,
    output logic        vram_sel_o,
    output vram_addr_t  vram_addr_o,
    output logic        font_sel_o,
    output font_addr_t  font_addr_o,
    output pal_index_t  pal_index_o,
    output logic        text_en_o
);

    // tile slot to pal_index_o is 6 clocks and de trails the scan by 1
    localparam int         FETCH_DEPTH = 6;
    localparam int         SLOT_LAG    = `VID_FETCH_LEAD + 1 - FETCH_DEPTH;   // open to first slot
    localparam logic [2:0] TILE_X_OPEN = 3'((8 - SLOT_LAG) % 8);

    logic [2:0] tile_x;                     // phase within the 8 clock tile period
    logic [3:0] tile_y;                     // row within the character cell
    vram_addr_t text_addr;                  // next tile word to read
    vram_addr_t text_line_addr;             // first tile word of the current text row
    logic [7:0] tile_color;                 // colour byte waiting for the shifter load
    logic [7:0] text_color;                 // bg in 7:4 and fg in 3:0 of the tile on screen
    logic [7:0] glyph_shift;                // msb is the current pixel
    logic [7:0] glyph_row;
    font_addr_t font_addr;

    // tall cells need 8 words per char and give up the top usable bank bit
    assign font_addr = cfg_i.font_height[3] ? {cfg_i.font_bank[0], vram_data_i[7:0], tile_y[3:1]}
                                            : {cfg_i.font_bank[1:0], vram_data_i[7:0], tile_y[2:1]};
    assign glyph_row = tile_y[0] ? font_data_i[7:0] : font_data_i[15:8];  // even row in upper byte

    always_ff @(posedge clk) begin
        if (reset_i) begin
            text_en_o      <= 1'b0;         // off until the first frame end
            tile_x         <= TILE_X_OPEN;
            tile_y         <= 4'd0;
            text_addr      <= '0;
            text_line_addr <= '0;
            vram_sel_o     <= 1'b0;
            font_sel_o     <= 1'b0;
            glyph_shift    <= 8'h00;
            text_color     <= 8'h00;
            pal_index_o    <= '0;
        end else begin
            vram_sel_o  <= 1'b0;            // selects are one clock strobes
            font_sel_o  <= 1'b0;
            glyph_shift <= {glyph_shift[6:0], 1'b0};
            tile_x      <= scan_i.fetch ? tile_x + 3'd1 : TILE_X_OPEN;

            if (scan_i.fetch) begin
                case (tile_x)
                    3'd0: begin
                        vram_sel_o <= text_en_o;            // tile word read
                        text_addr  <= text_addr + 1'b1;
                    end
                    3'd2: begin
                        font_sel_o <= text_en_o;            // glyph read from the tile char
                    end
                    3'd4: begin
                        glyph_shift <= glyph_row;           // previous tile just finished
                        text_color  <= tile_color;
                    end
                    default: begin
                    end
                endcase
            end

            pal_index_o <= glyph_shift[7] ? text_color[3:0] : text_color[7:4];

            if (scan_i.line_end) begin
                text_addr <= text_line_addr;                // repeat the row for the next cell line
                if (tile_y >= cfg_i.font_height) begin
                    tile_y         <= 4'd0;
                    text_line_addr <= text_line_addr + cfg_i.line_width;
                    text_addr      <= text_line_addr + cfg_i.line_width;
                end else begin
                    tile_y <= tile_y + 4'd1;
                end
            end

            if (scan_i.frame_end) begin
                text_en_o      <= enable_i;
                tile_y         <= 4'd0;
                text_addr      <= cfg_i.text_start;
                text_line_addr <= cfg_i.text_start;
            end
        end
    end

    // addresses and the saved colour only matter while a select is out
    always_ff @(posedge clk) begin
        if (scan_i.fetch && tile_x == 3'd0) begin
            vram_addr_o <= text_addr;
        end
        if (scan_i.fetch && tile_x == 3'd2) begin
            tile_color  <= vram_data_i[15:8];               // vram answered this clock
            font_addr_o <= font_addr;
        end
    end

    // one memory port at a time
    a_sel_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(vram_sel_o && font_sel_o));

    // reads stay on visible lines, from the back porch to the end of the line
    a_sel_in_window: assert property (@(posedge clk) disable iff (reset_i)
        (vram_sel_o || font_sel_o) |->
            ((scan_i.v_state == VISIBLE) &&
             (scan_i.h_state == POST_SYNC || scan_i.h_state == VISIBLE)));

endmodule

// ==== video_gen.sv ====
// text mode video generator top joining scan timing, config registers and the tile fetch path
`timescale 1ns/1ps

module video_gen
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       enable_i,            // sampled at frame end
    input  logic       vid_reg_wr_i,
    input  reg_num_t   vid_reg_num_i,
    input  reg_word_t  vid_reg_data_i,
    output reg_word_t  vid_reg_data_o,
    output logic       vram_sel_o,
    output vram_addr_t vram_addr_o,
    input  vram_word_t vram_data_i,         // valid the clock after vram_sel_o
    output logic       font_sel_o,
    output font_addr_t font_addr_o,
    input  font_word_t font_data_i,         // valid the clock after font_sel_o
    output pal_index_t pal_index_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       dv_de_o
);

    scan_state_t scan;
    text_cfg_t   text_cfg;
    logic        de;                        // raw visible area
    logic        text_en;                   // per frame enable

    video_sync u_sync (
        .clk     (clk),
        .reset_i (reset_i),
        .scan_o  (scan),
        .hsync_o (hsync_o),
        .vsync_o (vsync_o),
        .de_o    (de)
    );

    video_regs u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .scan_i     (scan),
        .reg_wr_i   (vid_reg_wr_i),
        .reg_num_i  (vid_reg_num_i),
        .reg_data_i (vid_reg_data_i),
        .cfg_o      (text_cfg),
        .reg_data_o (vid_reg_data_o)
    );

    text_fetch u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .scan_i      (scan),
        .cfg_i       (text_cfg),
        .enable_i    (enable_i),
        .vram_data_i (vram_data_i),
        .font_data_i (font_data_i),
        .vram_sel_o  (vram_sel_o),
        .vram_addr_o (vram_addr_o),
        .font_sel_o  (font_sel_o),
        .font_addr_o (font_addr_o),
        .pal_index_o (pal_index_o),
        .text_en_o   (text_en)
    );

    assign dv_de_o = de & text_en;          // blank frames keep de low

endmodule

// ==== video_gen_tb.sv ====
// self checking testbench for the text video generator, compiled from build.f with top video_gen_tb
`timescale 1ns/1ps
`include "video_cfg.svh"

module video_gen_tb
    import video_pkg::*;
();

    localparam int H_TOTAL = `VID_H_VISIBLE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK;
    localparam int V_TOTAL = `VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK;
    localparam int FRAME   = H_TOTAL * V_TOTAL;                 // clocks per frame
    localparam int PIXELS  = `VID_H_VISIBLE * `VID_V_VISIBLE;

    logic       clk;
    logic       reset_i;
    logic       enable_i;
    logic       vid_reg_wr_i;
    reg_num_t   vid_reg_num_i;
    reg_word_t  vid_reg_data_i;
    reg_word_t  vid_reg_data_o;
    logic       vram_sel_o;
    vram_addr_t vram_addr_o;
    vram_word_t vram_data_i;
    logic       font_sel_o;
    font_addr_t font_addr_o;
    font_word_t font_data_i;
    pal_index_t pal_index_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    vram_word_t vram_mem [65536];
    font_word_t font_mem [4096];

    int         error_count;
    int         tests_run;
    int         tests_failed;
    logic       aborted;                 // a wait ran out of time
    logic       pix_on;                  // pixel compare armed
    int         pix_x;
    int         pix_y;
    int         pix_count;
    string      pix_name;
    vram_addr_t ref_start;               // layout the reference assumes
    vram_addr_t ref_width;
    logic [3:0] ref_height;
    int         m_hs_pulses;             // results of one measured frame
    int         m_hs_bad_width;
    int         m_hs_bad_period;
    int         m_vs_low;
    int         m_de_high;

    video_gen dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;           // 4 ns period
    end

    // both memories answer the clock after their select and hold the word
    always @(posedge clk) begin
        if (vram_sel_o) vram_data_i <= vram_mem[vram_addr_o];
        if (font_sel_o) font_data_i <= font_mem[font_addr_o];
    end

    // pixel expected from the tile layout, cell row and glyph bit, bank 0 only
    function automatic pal_index_t expected_pixel(int x, int y, vram_addr_t start,
                                                  vram_addr_t width, logic [3:0] h);
        int         cell_h;
        int         row;
        vram_addr_t tile_addr;
        vram_word_t tile;
        font_addr_t glyph_addr;
        font_word_t glyph;
        logic [7:0] glyph_byte;
        cell_h     = int'(h) + 1;
        row        = y % cell_h;
        tile_addr  = vram_addr_t'(int'(start) + (y / cell_h) * int'(width) + x / 8);  // wraps
        tile       = vram_mem[tile_addr];
        glyph_addr = font_addr_t'(int'(tile[7:0]) * (cell_h > 8 ? 8 : 4) + row / 2);
        glyph      = font_mem[glyph_addr];
        glyph_byte = (row % 2 == 1) ? glyph[7:0] : glyph[15:8];   // even row in upper byte
        return glyph_byte[7 - x % 8] ? tile[11:8] : tile[15:12];   // fg or bg
    endfunction

    task automatic check_reg(string name, reg_word_t exp, reg_word_t act);
        if (act !== exp) begin
            error_count++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_pix(string name, int x, int y, pal_index_t exp, pal_index_t act);
        if (act !== exp) begin
            error_count++;
            $display("** Error %s at x %0d y %0d: expected %h, actual %h", name, x, y, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            error_count++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic report_timeout(string what);
        $display("timeout while waiting for %s", what);
        error_count++;
        aborted = 1'b1;
    endtask

    task automatic end_test(string name, int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, error_count - errs_before);
        end
    endtask

    // compare every displayed pixel against the reference
    always @(negedge clk) begin
        if (pix_on && dv_de_o) begin
            check_pix(pix_name, pix_x, pix_y,
                      expected_pixel(pix_x, pix_y, ref_start, ref_width, ref_height),
                      pal_index_o);
            pix_count++;
            if (pix_x == `VID_H_VISIBLE - 1) begin
                pix_x = 0;
                pix_y++;
            end else begin
                pix_x++;
            end
        end
    end

    task automatic write_reg(input reg_num_t num, input reg_word_t data);
        @(posedge clk);
        vid_reg_wr_i   <= 1'b1;
        vid_reg_num_i  <= num;
        vid_reg_data_i <= data;
        @(posedge clk);
        vid_reg_wr_i   <= 1'b0;
    endtask

    task automatic read_reg(input reg_num_t num, output reg_word_t data);
        @(posedge clk);
        vid_reg_num_i <= num;
        @(posedge clk);                  // readback registers here
        @(negedge clk);
        data = vid_reg_data_o;
    endtask

    // returns on the first clock of the next vsync pulse
    task automatic wait_vsync_start();
        int n;
        n = 0;
        @(negedge clk);
        while (!aborted && vsync_o == `VID_V_SYNC_POL) begin   // skip a pulse in progress
            @(negedge clk);
            n++;
            if (n > FRAME) report_timeout("vsync to go idle");
        end
        n = 0;
        while (!aborted && vsync_o != `VID_V_SYNC_POL) begin
            @(negedge clk);
            n++;
            if (n > 2 * FRAME) report_timeout("the next vsync pulse");
        end
    endtask

    // one frame from vsync start, hsync pulse widths and spacing plus level counts
    task automatic measure_frame();
        int   run;
        int   since_fall;
        logic hs_prev;
        m_hs_pulses     = 0;
        m_hs_bad_width  = 0;
        m_hs_bad_period = 0;
        m_vs_low        = 0;
        m_de_high       = 0;
        run             = 0;
        since_fall      = 0;
        hs_prev         = ~`VID_H_SYNC_POL;
        wait_vsync_start();
        for (int i = 0; i < FRAME && !aborted; i++) begin
            if (hsync_o == `VID_H_SYNC_POL) begin
                if (hs_prev != `VID_H_SYNC_POL) begin                 // pulse starts
                    if (m_hs_pulses > 0 && since_fall != H_TOTAL) m_hs_bad_period++;
                    m_hs_pulses++;
                    since_fall = 0;
                end
                run++;
            end else if (run > 0) begin
                if (run != `VID_H_SYNC) m_hs_bad_width++;
                run = 0;
            end
            if (vsync_o == `VID_V_SYNC_POL) m_vs_low++;
            if (dv_de_o) m_de_high++;
            hs_prev = hsync_o;
            since_fall++;
            @(negedge clk);
        end
    endtask

    task automatic test_readback();
        int        errs;
        reg_word_t val;
        errs = error_count;
        read_reg(3'd0, val);
        check_reg("readback", reg_word_t'(`VID_H_VISIBLE), val);
        read_reg(3'd1, val);
        check_reg("readback", reg_word_t'(`VID_V_VISIBLE), val);
        read_reg(3'd2, val);
        check_reg("readback", `VID_FEATURES, val);
        end_test("readback", errs);
    endtask

    task automatic test_frame_timing();
        int errs;
        errs = error_count;
        @(posedge clk);
        enable_i <= 1'b1;                // taken at the first frame end
        measure_frame();
        check_count("frame timing hsync pulses", V_TOTAL, m_hs_pulses);
        check_count("frame timing bad hsync widths", 0, m_hs_bad_width);
        check_count("frame timing bad hsync periods", 0, m_hs_bad_period);
        check_count("frame timing vsync clocks", `VID_V_SYNC * H_TOTAL, m_vs_low);
        check_count("frame timing de clocks", PIXELS, m_de_high);
        end_test("frame timing", errs);
    endtask

    task automatic test_enable_low();
        int errs;
        errs = error_count;
        @(posedge clk);
        enable_i <= 1'b0;
        measure_frame();
        check_count("enable low de clocks", 0, m_de_high);
        end_test("enable low", errs);
    endtask

    task automatic test_text(string name, vram_addr_t start, logic [3:0] height);
        int errs;
        int n;
        errs = error_count;
        @(posedge clk);
        enable_i <= 1'b1;
        write_reg(`VID_REG_DISPSTART, start);
        write_reg(`VID_REG_TILEWIDTH, 16'd80);
        write_reg(3'd2, reg_word_t'($urandom));      // unmapped scroll slot
        write_reg(`VID_REG_FONTCTRL, {12'h000, height});
        ref_start  = start;
        ref_width  = 16'd80;
        ref_height = height;
        pix_name   = name;
        wait_vsync_start();                          // new layout starts at the next frame
        pix_x      = 0;
        pix_y      = 0;
        pix_count  = 0;
        pix_on     = 1'b1;
        n          = 0;
        while (!aborted && pix_count < PIXELS) begin
            @(posedge clk);
            n++;
            if (n > 2 * FRAME) report_timeout("a frame of text pixels");
        end
        pix_on = 1'b0;
        end_test(name, errs);
    endtask

    task automatic test_status();
        int        errs;
        int        vc;
        int        vc_prev;
        int        wraps;
        int        v_blank;
        int        h_blank;
        int        flag_bad;
        reg_word_t st;
        errs     = error_count;
        vc_prev  = 0;
        wraps    = 0;
        v_blank  = 0;
        h_blank  = 0;
        flag_bad = 0;
        @(posedge clk);
        vid_reg_num_i <= 3'd3;
        wait_vsync_start();
        for (int i = 0; i < FRAME && !aborted; i++) begin
            st = vid_reg_data_o;
            vc = int'(st[10:0]);
            if (st[15] != (vc >= `VID_V_VISIBLE)) flag_bad++;
            if (st[15]) v_blank++;
            if (st[14]) h_blank++;
            if (vc < vc_prev) wraps++;               // only at the frame boundary
            vc_prev = vc;
            @(negedge clk);
        end
        check_count("status v blank clocks", (V_TOTAL - `VID_V_VISIBLE) * H_TOTAL, v_blank);
        check_count("status h blank clocks", (H_TOTAL - `VID_H_VISIBLE) * V_TOTAL, h_blank);
        check_count("status blank flag mismatches", 0, flag_bad);
        check_count("status line count wraps", 1, wraps);
        end_test("status", errs);
    endtask

    initial begin
        void'($urandom(32'hb831_d893));
        for (int i = 0; i < 65536; i++) vram_mem[i] = vram_word_t'($urandom);
        for (int i = 0; i < 4096; i++) font_mem[i] = font_word_t'($urandom);
        error_count    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        aborted        = 1'b0;
        pix_on         = 1'b0;
        reset_i        = 1'b1;
        enable_i       = 1'b0;
        vid_reg_wr_i   = 1'b0;
        vid_reg_num_i  = '0;
        vid_reg_data_i = '0;
        vram_data_i    = '0;
        font_data_i    = '0;
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;
        test_readback();
        if (!aborted) test_frame_timing();
        if (!aborted) test_enable_low();
        if (!aborted) test_text("text h15", 16'h1234, 4'd15);
        if (!aborted) test_text("text h7", 16'hf000, 4'd7);     // rows run past vram end
        if (!aborted) test_status();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
video_pkg.sv
video_sync.sv
video_regs.sv
text_fetch.sv
video_gen.sv
video_gen_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the video generator testbench with verilator, run it and check for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module video_gen_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vvideo_gen_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
